/* verif/rename_cases.txt */
# Commands: rename v rd rs1 rs2 per lane (lane 0 first) | retire n | mispredict n
# mispredict retires n oldest in the same cycle | random n cycles | free n expected count
free 32
# Identity map after reset, r0 allocates nothing
rename 1 0 3 4 1 0 5 6
free 32
rename 1 1 2 3 1 2 1 1
# Lane 1 reads and rewrites lane 0 rd
rename 1 3 1 2 1 3 3 3
rename 1 5 3 4 0 0 0 0
free 27
retire 2
free 29
# Freed tags come back lowest first
rename 1 6 1 5 1 7 6 6
free 27
# Drain the free list down to one register
rename 1 8 1 2 1 9 8 3
rename 1 10 9 9 1 11 4 10
rename 1 12 5 6 1 13 12 12
rename 1 14 7 8 1 15 14 1
rename 1 16 2 3 1 17 16 16
rename 1 18 17 4 1 19 18 5
rename 1 20 6 7 1 21 20 20
rename 1 22 9 10 1 23 22 11
rename 1 24 12 13 1 25 24 24
rename 1 26 14 15 1 27 26 16
rename 1 28 17 18 1 29 28 28
rename 1 30 19 20 1 31 30 21
rename 1 8 22 23 1 9 8 8
free 1
# Held group, released by a retire beside it
rename 1 10 8 9 1 11 10 10
free 1
mispredict 2
free 32
rename 1 0 5 6 1 0 3 7
random 300
mispredict 1
free 32
rename 1 4 4 0 1 4 4 4
retire 2

/* filelist.f */
verilog/rename_pkg.sv
verilog/retire_if.sv
verilog/map_table.sv
verilog/free_list.sv
verilog/arch_map_table.sv
verilog/rename_unit.sv
verif/rename_checker.sv
verif/rename_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile the rename testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing -f filelist.f --top-module rename_tb -Mdir "$OBJ_DIR" -o rename_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$OBJ_DIR/rename_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

/* verif/rename_tb.sv */
// Rename testbench
// Runs the command lines of the case file against the rename unit, with
// LFSR random groups and retires taken from its own in-flight queue

`timescale 1ns/10ps

module rename_tb;

    localparam int WIDTH         = 2;
    localparam int READY_TIMEOUT = 50;
    // Stalled cycles before retiring beside a held group
    localparam int STALL_RETIRE  = 4;

    logic                              clock;
    logic                              reset;
    logic                  [WIDTH-1:0] rename_valid;
    rename_pkg::arch_reg_t [WIDTH-1:0] rename_rd;
    rename_pkg::arch_reg_t [WIDTH-1:0] rename_rs1;
    rename_pkg::arch_reg_t [WIDTH-1:0] rename_rs2;
    logic                  [WIDTH-1:0] retire_valid;
    rename_pkg::arch_reg_t [WIDTH-1:0] retire_rd;
    rename_pkg::phys_tag_t [WIDTH-1:0] retire_tag;
    rename_pkg::phys_tag_t [WIDTH-1:0] retire_told;
    logic                              mispredict;
    logic                              rename_ready;
    rename_pkg::phys_tag_t [WIDTH-1:0] src1_tag;
    rename_pkg::phys_tag_t [WIDTH-1:0] src2_tag;
    rename_pkg::phys_tag_t [WIDTH-1:0] dest_tag;
    rename_pkg::phys_tag_t [WIDTH-1:0] told_tag;
    rename_pkg::free_count_t           free_count;

    // Checker side
    logic                              expect_free_valid;
    int                                expect_free;
    rename_pkg::phys_tag_t [WIDTH-1:0] pred_dest;
    rename_pkg::phys_tag_t [WIDTH-1:0] pred_told;
    int                                error_count;
    int                                check_count;

    // In-flight instructions, oldest first
    int q_rd   [$];
    int q_tag  [$];
    int q_told [$];

    logic [31:0] lfsr;
    logic        ready_seen;
    logic        timed_out;
    logic        bad_file;

    rename_unit #(.WIDTH(WIDTH)) rename_unit_i (.*);

    rename_checker #(.WIDTH(WIDTH)) rename_checker_i (.*);

    initial clock = 1'b0;
    always #20 clock = ~clock;

    // Ready as seen mid-cycle, read at the next rising edge
    always @(negedge clock) ready_seen <= rename_ready;

    //////////////////////////////////////////////////////////////////////
    // Random source
    //////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int k = 0; k < count; k++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////////////////////////

    // Oldest entries onto the retire lanes, no clock
    task automatic load_retire(input int count);
        retire_valid = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if ((i < count) && (q_rd.size() > 0)) begin
                retire_valid[i] = 1'b1;
                retire_rd[i]    = rename_pkg::arch_reg_t'(q_rd.pop_front());
                retire_tag[i]   = rename_pkg::phys_tag_t'(q_tag.pop_front());
                retire_told[i]  = rename_pkg::phys_tag_t'(q_told.pop_front());
            end
        end
    endtask

    task automatic retire_oldest(input int count);
        int left;
        left = count;
        while (left > 0) begin
            load_retire(left);
            left = left - WIDTH;
            @(posedge clock);
            #1;
            retire_valid = '0;
        end
    endtask

    task automatic rename_group(input logic [WIDTH-1:0] valid,
                                input rename_pkg::arch_reg_t [WIDTH-1:0] rd,
                                input rename_pkg::arch_reg_t [WIDTH-1:0] rs1,
                                input rename_pkg::arch_reg_t [WIDTH-1:0] rs2);
        int   waited;
        logic accepted;
        waited       = 0;
        accepted     = 1'b0;
        rename_valid = valid;
        rename_rd    = rd;
        rename_rs1   = rs1;
        rename_rs2   = rs2;
        while (!accepted && (waited < READY_TIMEOUT)) begin
            @(posedge clock);
            if (ready_seen) begin
                accepted = 1'b1;
                // Queue holds the model's tags for later retirement
                for (int i = 0; i < WIDTH; i++) begin
                    if (valid[i] && (rd[i] != '0)) begin
                        q_rd.push_back(int'(rd[i]));
                        q_tag.push_back(int'(pred_dest[i]));
                        q_told.push_back(int'(pred_told[i]));
                    end
                end
            end else begin
                waited++;
            end
            #1;
            retire_valid = '0;
            // One retire beside the held group makes room
            if (!accepted && (waited == STALL_RETIRE)) begin
                load_retire(WIDTH);
            end
        end
        rename_valid = '0;
        if (!accepted) begin
            timed_out = 1'b1;
            $display("Timeout: rename_ready stayed low for %0d cycles", READY_TIMEOUT);
        end
    endtask

    task automatic mispredict_with_retire(input int count);
        if (count > WIDTH) begin
            retire_oldest(count - WIDTH);
        end
        load_retire((count > WIDTH) ? WIDTH : count);
        mispredict = 1'b1;
        @(posedge clock);
        #1;
        mispredict   = 1'b0;
        retire_valid = '0;
        // All younger work is squashed
        q_rd.delete();
        q_tag.delete();
        q_told.delete();
    endtask

    task automatic random_cycles(input int cycles);
        logic [31:0]                       pick;
        logic [WIDTH-1:0]                  valid;
        rename_pkg::arch_reg_t [WIDTH-1:0] rd;
        rename_pkg::arch_reg_t [WIDTH-1:0] rs1;
        rename_pkg::arch_reg_t [WIDTH-1:0] rs2;
        for (int n = 0; (n < cycles) && !timed_out; n++) begin
            random_bits(2, pick);
            // Three renames in four, so the free list drains
            if ((pick[1:0] != 2'b11) || (q_rd.size() == 0)) begin
                random_bits(WIDTH, pick);
                valid = pick[WIDTH-1:0];
                for (int i = 0; i < WIDTH; i++) begin
                    random_bits(5, pick);
                    rd[i] = pick[4:0];
                    random_bits(5, pick);
                    rs1[i] = pick[4:0];
                    random_bits(5, pick);
                    rs2[i] = pick[4:0];
                end
                rename_group(valid, rd, rs1, rs2);
            end else begin
                random_bits(1, pick);
                retire_oldest(int'(pick[0]) + 1);
            end
        end
    endtask

    task automatic check_free(input int expected);
        expect_free       = expected;
        expect_free_valid = 1'b1;
        @(posedge clock);
        #1;
        expect_free_valid = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Case file runner
    //////////////////////////////////////////////////////////////////////

    initial begin
        int                                fd;
        int                                code;
        int                                arg;
        int                                tests;
        int                                errors_before;
        int                                v;
        int                                d;
        int                                s1;
        int                                s2;
        string                             cmd;
        string                             rest;
        logic                              done;
        logic                  [WIDTH-1:0] valid;
        rename_pkg::arch_reg_t [WIDTH-1:0] rd;
        rename_pkg::arch_reg_t [WIDTH-1:0] rs1;
        rename_pkg::arch_reg_t [WIDTH-1:0] rs2;
        reset             = 1'b1;
        rename_valid      = '0;
        rename_rd         = '0;
        rename_rs1        = '0;
        rename_rs2        = '0;
        retire_valid      = '0;
        retire_rd         = '0;
        retire_tag        = '0;
        retire_told       = '0;
        mispredict        = 1'b0;
        expect_free_valid = 1'b0;
        expect_free       = 0;
        lfsr              = 32'h6acd;
        timed_out         = 1'b0;
        bad_file          = 1'b0;
        done              = 1'b0;
        tests             = 0;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;

        fd = $fopen("verif/rename_cases.txt", "r");
        if (fd == 0) begin
            bad_file = 1'b1;
            done     = 1'b1;
            $display("Could not open verif/rename_cases.txt");
        end
        while (!done && !timed_out) begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1) begin
                done = 1'b1;
            end else if (cmd == "#") begin
                code = $fgets(rest, fd);
            end else begin
                errors_before = error_count;
                arg           = 0;
                if (cmd == "rename") begin
                    // One quadruple per lane, lane 0 first
                    for (int i = 0; i < WIDTH; i++) begin
                        code   = $fscanf(fd, "%d %d %d %d", v, d, s1, s2);
                        valid[i] = (v != 0);
                        rd[i]    = rename_pkg::arch_reg_t'(d);
                        rs1[i]   = rename_pkg::arch_reg_t'(s1);
                        rs2[i]   = rename_pkg::arch_reg_t'(s2);
                    end
                    rename_group(valid, rd, rs1, rs2);
                end else begin
                    code = $fscanf(fd, "%d", arg);
                    if (cmd == "retire") begin
                        retire_oldest(arg);
                    end else if (cmd == "mispredict") begin
                        mispredict_with_retire(arg);
                    end else if (cmd == "random") begin
                        random_cycles(arg);
                    end else if (cmd == "free") begin
                        check_free(arg);
                    end else begin
                        bad_file = 1'b1;
                        done     = 1'b1;
                        $display("Unknown command %s in case file", cmd);
                    end
                end
                tests++;
                $display("Test %0d %s %0d done, %0d errors", tests, cmd, arg,
                         error_count - errors_before);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        repeat (2) @(posedge clock);
        $display("Tests %0d, checks %0d, errors %0d", tests, check_count, error_count);
        if ((error_count == 0) && !timed_out && !bad_file) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verif/rename_checker.sv */
// Rename checker
// Reference model of the speculative map, free bitmap and architected map.
// Compares the DUT outputs at every falling edge and predicts the rename tags

`timescale 1ns/10ps

module rename_checker #(
    parameter int WIDTH = 2
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                  [WIDTH-1:0] rename_valid,
    input  rename_pkg::arch_reg_t [WIDTH-1:0] rename_rd,
    input  rename_pkg::arch_reg_t [WIDTH-1:0] rename_rs1,
    input  rename_pkg::arch_reg_t [WIDTH-1:0] rename_rs2,
    input  logic                  [WIDTH-1:0] retire_valid,
    input  rename_pkg::arch_reg_t [WIDTH-1:0] retire_rd,
    input  rename_pkg::phys_tag_t [WIDTH-1:0] retire_tag,
    input  rename_pkg::phys_tag_t [WIDTH-1:0] retire_told,
    input  logic                              mispredict,
    input  logic                              rename_ready,
    input  rename_pkg::phys_tag_t [WIDTH-1:0] src1_tag,
    input  rename_pkg::phys_tag_t [WIDTH-1:0] src2_tag,
    input  rename_pkg::phys_tag_t [WIDTH-1:0] dest_tag,
    input  rename_pkg::phys_tag_t [WIDTH-1:0] told_tag,
    input  rename_pkg::free_count_t           free_count,
    // Free count given by the case file
    input  logic                              expect_free_valid,
    input  int                                expect_free,
    output rename_pkg::phys_tag_t [WIDTH-1:0] pred_dest,
    output rename_pkg::phys_tag_t [WIDTH-1:0] pred_told,
    output int                                error_count,
    output int                                check_count
);

    localparam int ARCH = rename_pkg::NUM_ARCH_REGS;
    localparam int PHYS = rename_pkg::NUM_PHYS_REGS;

    // Model state
    int spec_map [ARCH];
    int arch_map [ARCH];
    bit free_bit [PHYS];
    int free_total;

    // Working copies while one group walks through its lanes
    int work_map [ARCH];
    bit work_free [PHYS];
    bit ready_exp;
    int e_dest;
    int e_told;

    task automatic compare_value(input string name, input int expected, input int actual);
        check_count++;
        if (expected != actual) begin
            error_count++;
            $display("Fail %0t ns %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    always @(negedge clock) begin
        if (reset) begin
            // Identity maps, upper half free
            for (int a = 0; a < ARCH; a++) begin
                spec_map[a] = a;
                arch_map[a] = a;
            end
            for (int p = 0; p < PHYS; p++) begin
                free_bit[p] = (p >= ARCH);
            end
            free_total = PHYS - ARCH;
            pred_dest  = '0;
            pred_told  = '0;
        end else begin
            ready_exp = (free_total >= WIDTH) && !mispredict;
            compare_value("rename_ready", int'(ready_exp), int'(rename_ready));
            compare_value("free_count", free_total, int'(free_count));
            if (expect_free_valid) begin
                compare_value("free_count (case file)", expect_free, int'(free_count));
            end

            // Lanes in order, each one sees the writes of the lanes before it
            work_map  = spec_map;
            work_free = free_bit;
            for (int i = 0; i < WIDTH; i++) begin
                e_told = work_map[rename_rd[i]];
                if (rename_valid[i]) begin
                    compare_value($sformatf("src1_tag[%0d]", i),
                                  work_map[rename_rs1[i]], int'(src1_tag[i]));
                    compare_value($sformatf("src2_tag[%0d]", i),
                                  work_map[rename_rs2[i]], int'(src2_tag[i]));
                    compare_value($sformatf("told_tag[%0d]", i), e_told, int'(told_tag[i]));
                end
                e_dest = 0;
                if (rename_valid[i] && (rename_rd[i] != '0) && ready_exp) begin
                    // Lowest free register above p0
                    for (int p = 1; (p < PHYS) && (e_dest == 0); p++) begin
                        if (work_free[p]) begin
                            e_dest = p;
                        end
                    end
                    work_free[e_dest]      = 1'b0;
                    work_map[rename_rd[i]] = e_dest;
                end
                compare_value($sformatf("dest_tag[%0d]", i), e_dest, int'(dest_tag[i]));
                pred_dest[i] = rename_pkg::phys_tag_t'(e_dest);
                pred_told[i] = rename_pkg::phys_tag_t'(e_told);
            end

            // Retirement commits and frees the old tag
            for (int i = 0; i < WIDTH; i++) begin
                if (retire_valid[i] && (retire_rd[i] != '0)) begin
                    arch_map[retire_rd[i]] = int'(retire_tag[i]);
                end
                if (retire_valid[i] && (retire_told[i] != '0)) begin
                    work_free[retire_told[i]] = 1'b1;
                end
            end

            if (mispredict) begin
                // Everything not held by the committed map is free
                spec_map = arch_map;
                for (int p = 0; p < PHYS; p++) begin
                    work_free[p] = 1'b1;
                end
                for (int a = 0; a < ARCH; a++) begin
                    work_free[arch_map[a]] = 1'b0;
                end
            end else begin
                spec_map = work_map;
            end
            free_bit   = work_free;
            free_total = 0;
            for (int p = 0; p < PHYS; p++) begin
                if (free_bit[p]) begin
                    free_total++;
                end
            end
        end
    end

endmodule

/* verilog/rename_unit.sv */
// Register rename unit
// Speculative map, free list and architected map, joined to plain ports

`timescale 1ns/10ps

module rename_unit #(
    parameter int WIDTH = 2
) (
    input  logic                              clock,
    input  logic                              reset,
    // Rename group
    input  logic                  [WIDTH-1:0] rename_valid,
    input  rename_pkg::arch_reg_t [WIDTH-1:0] rename_rd,
    input  rename_pkg::arch_reg_t [WIDTH-1:0] rename_rs1,
    input  rename_pkg::arch_reg_t [WIDTH-1:0] rename_rs2,
    // Retire group
    input  logic                  [WIDTH-1:0] retire_valid,
    input  rename_pkg::arch_reg_t [WIDTH-1:0] retire_rd,
    input  rename_pkg::phys_tag_t [WIDTH-1:0] retire_tag,
    input  rename_pkg::phys_tag_t [WIDTH-1:0] retire_told,
    input  logic                              mispredict,
    // Rename results
    output logic                              rename_ready,
    output rename_pkg::phys_tag_t [WIDTH-1:0] src1_tag,
    output rename_pkg::phys_tag_t [WIDTH-1:0] src2_tag,
    output rename_pkg::phys_tag_t [WIDTH-1:0] dest_tag,
    output rename_pkg::phys_tag_t [WIDTH-1:0] told_tag,
    output rename_pkg::free_count_t           free_count
);

    logic                  [WIDTH-1:0] alloc_req;
    rename_pkg::phys_tag_t [WIDTH-1:0] alloc_tags;
    rename_pkg::map_array_t            arch_next;

    //////////////////////////////////////////////////////////////////////
    // Retire bus
    //////////////////////////////////////////////////////////////////////

    retire_if #(.WIDTH(WIDTH)) retire_bus ();

    assign retire_bus.valid = retire_valid;
    assign retire_bus.rd    = retire_rd;
    assign retire_bus.tag   = retire_tag;
    assign retire_bus.told  = retire_told;

    //////////////////////////////////////////////////////////////////////
    // Tables
    //////////////////////////////////////////////////////////////////////

    map_table #(.WIDTH(WIDTH)) map_table_i (
        .clock        (clock),
        .reset        (reset),
        .mispredict   (mispredict),
        .rename_valid (rename_valid),
        .rename_rd    (rename_rd),
        .rename_rs1   (rename_rs1),
        .rename_rs2   (rename_rs2),
        .alloc_tags   (alloc_tags),
        .rename_ready (rename_ready),
        .arch_next    (arch_next),
        .alloc_req    (alloc_req),
        .src1_tag     (src1_tag),
        .src2_tag     (src2_tag),
        .dest_tag     (dest_tag),
        .told_tag     (told_tag)
    );

    free_list #(.WIDTH(WIDTH)) free_list_i (
        .clock        (clock),
        .reset        (reset),
        .mispredict   (mispredict),
        .alloc_req    (alloc_req),
        .retire       (retire_bus.releases),
        .arch_next    (arch_next),
        .alloc_tags   (alloc_tags),
        .rename_ready (rename_ready),
        .free_count   (free_count)
    );

    // Also the restore source for the other two tables
    arch_map_table #(.WIDTH(WIDTH)) arch_map_table_i (
        .clock        (clock),
        .reset        (reset),
        .retire       (retire_bus.commit),
        .arch_next    (arch_next)
    );

endmodule

/* verilog/arch_map_table.sv */
// Architected map table
// Committed arch-to-phys map, written by retirement in lane order;
// the next value feeds mispredict recovery

`timescale 1ns/10ps

module arch_map_table #(
    parameter int WIDTH = 2
) (
    input  logic                   clock,
    input  logic                   reset,
    retire_if.commit               retire,
    output rename_pkg::map_array_t arch_next
);

    rename_pkg::map_array_t arch_q;

    // Apply the retire group, later lanes overwrite earlier ones
    always_comb begin
        arch_next = arch_q;
        for (int i = 0; i < WIDTH; i++) begin
            // r0 stays pinned to p0
            if (retire.valid[i] && (retire.rd[i] != '0)) begin
                arch_next[retire.rd[i]] = retire.tag[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            arch_q <= rename_pkg::identity_map();
        end else begin
            arch_q <= arch_next;
        end
    end

endmodule

/* verilog/free_list.sv */
// Physical register free list
// Bitmap with lowest-first allocation per lane, release of retired tags,
// and rebuild from the committed map on mispredict

`timescale 1ns/10ps

module free_list #(
    parameter int WIDTH = 2
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              mispredict,
    input  logic                  [WIDTH-1:0] alloc_req,
    retire_if.releases                        retire,
    input  rename_pkg::map_array_t            arch_next,
    output rename_pkg::phys_tag_t [WIDTH-1:0] alloc_tags,
    output logic                              rename_ready,
    output rename_pkg::free_count_t           free_count
);

    localparam int SPARE_REGS = rename_pkg::NUM_PHYS_REGS - rename_pkg::NUM_ARCH_REGS;

    // Upper half free out of reset, lower half backs the identity map
    localparam rename_pkg::phys_mask_t RESET_FREE =
        {{SPARE_REGS{1'b1}}, {rename_pkg::NUM_ARCH_REGS{1'b0}}};

    rename_pkg::phys_mask_t  free_q;
    rename_pkg::free_count_t count_q;

    rename_pkg::phys_mask_t  avail;
    rename_pkg::phys_tag_t   pick;
    rename_pkg::phys_mask_t  alloc_mask;
    rename_pkg::free_count_t alloc_n;
    rename_pkg::phys_mask_t  release_mask;
    rename_pkg::free_count_t release_n;
    rename_pkg::phys_mask_t  named;

    //////////////////////////////////////////////////////////////////////
    // Allocation
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        avail      = free_q;
        alloc_mask = '0;
        alloc_n    = '0;
        for (int i = 0; i < WIDTH; i++) begin
            // Downward scan leaves the lowest free bit; p0 is never free
            pick = '0;
            for (int p = rename_pkg::NUM_PHYS_REGS - 1; p > 0; p--) begin
                if (avail[p]) begin
                    pick = rename_pkg::phys_tag_t'(p);
                end
            end
            alloc_tags[i] = pick;
            // Hide the taken bit from later lanes
            if (alloc_req[i]) begin
                avail[pick]      = 1'b0;
                alloc_mask[pick] = 1'b1;
                alloc_n          = alloc_n + rename_pkg::free_count_t'(1);
            end
        end
    end

    // Release of told tags, p0 excluded
    always_comb begin
        release_mask = '0;
        release_n    = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (retire.valid[i] && (retire.told[i] != '0)) begin
                release_mask[retire.told[i]] = 1'b1;
                release_n = release_n + rename_pkg::free_count_t'(1);
            end
        end
    end

    // Registers held by the committed map, p0 among them
    always_comb begin
        named = '0;
        for (int a = 0; a < rename_pkg::NUM_ARCH_REGS; a++) begin
            named[arch_next[a]] = 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // State
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            free_q  <= RESET_FREE;
            count_q <= rename_pkg::free_count_t'(SPARE_REGS);
        end else if (mispredict) begin
            free_q  <= ~named;
            count_q <= rename_pkg::free_count_t'(SPARE_REGS);
        end else begin
            free_q  <= (free_q & ~alloc_mask) | release_mask;
            count_q <= count_q - alloc_n + release_n;
        end
    end

    // Full group must fit, and no renaming in the recovery cycle
    assign rename_ready = (count_q >= rename_pkg::free_count_t'(WIDTH)) && !mispredict;
    assign free_count   = count_q;

endmodule

/* verilog/map_table.sv */
// Speculative map table
// Renames a group of lanes against the speculative map with in-group bypass,
// and reloads the committed map on mispredict

`timescale 1ns/10ps

module map_table #(
    parameter int WIDTH = 2
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              mispredict,
    input  logic                  [WIDTH-1:0] rename_valid,
    input  rename_pkg::arch_reg_t [WIDTH-1:0] rename_rd,
    input  rename_pkg::arch_reg_t [WIDTH-1:0] rename_rs1,
    input  rename_pkg::arch_reg_t [WIDTH-1:0] rename_rs2,
    input  rename_pkg::phys_tag_t [WIDTH-1:0] alloc_tags,
    input  logic                              rename_ready,
    input  rename_pkg::map_array_t            arch_next,
    output logic                  [WIDTH-1:0] alloc_req,
    output rename_pkg::phys_tag_t [WIDTH-1:0] src1_tag,
    output rename_pkg::phys_tag_t [WIDTH-1:0] src2_tag,
    output rename_pkg::phys_tag_t [WIDTH-1:0] dest_tag,
    output rename_pkg::phys_tag_t [WIDTH-1:0] told_tag
);

    // Speculative arch-to-phys map
    rename_pkg::map_array_t map_q;

    //////////////////////////////////////////////////////////////////////
    // Lane lookup
    //////////////////////////////////////////////////////////////////////

    // r0 never allocates, and nothing moves while stalled
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            alloc_req[i] = rename_valid[i] && (rename_rd[i] != '0) && rename_ready;
        end
    end

    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            // Base read from the table
            src1_tag[i] = map_q[rename_rs1[i]];
            src2_tag[i] = map_q[rename_rs2[i]];
            told_tag[i] = map_q[rename_rd[i]];

            // Earlier lanes of the group win with the latest one last
            for (int j = 0; j < i; j++) begin
                if (alloc_req[j] && (rename_rd[j] == rename_rs1[i])) begin
                    src1_tag[i] = alloc_tags[j];
                end
                if (alloc_req[j] && (rename_rd[j] == rename_rs2[i])) begin
                    src2_tag[i] = alloc_tags[j];
                end
                if (alloc_req[j] && (rename_rd[j] == rename_rd[i])) begin
                    told_tag[i] = alloc_tags[j];
                end
            end

            // No new register for r0 or a stalled lane
            dest_tag[i] = alloc_req[i] ? alloc_tags[i] : '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Map update
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            map_q <= rename_pkg::identity_map();
        end else if (mispredict) begin
            // Recovery from the committed map, this cycle's retires included
            map_q <= arch_next;
        end else begin
            // Lane order, so the youngest write to a register sticks
            for (int i = 0; i < WIDTH; i++) begin
                if (alloc_req[i]) begin
                    map_q[rename_rd[i]] <= alloc_tags[i];
                end
            end
        end
    end

endmodule

/* verilog/retire_if.sv */
// Retire group bus
// Carries committed lanes to the architected map and freed tags to the free list

`timescale 1ns/10ps

interface retire_if #(
    parameter int WIDTH = 2
);

    logic                  [WIDTH-1:0] valid;
    rename_pkg::arch_reg_t [WIDTH-1:0] rd;
    // New mapping of rd, and the mapping it replaces
    rename_pkg::phys_tag_t [WIDTH-1:0] tag;
    rename_pkg::phys_tag_t [WIDTH-1:0] told;

    // Architected map side
    modport commit (input valid, rd, tag);
    // Free list side
    modport releases (input valid, told);

endinterface

/* verilog/rename_pkg.sv */
// Rename package
// Register counts, tag widths and the vector types used by the rename tables

package rename_pkg;

    //////////////////////////////////////////////////////////////////////
    // Register counts
    //////////////////////////////////////////////////////////////////////

    localparam int NUM_ARCH_REGS = 32;
    localparam int NUM_PHYS_REGS = 64;

    // Index and count widths
    localparam int ARCH_BITS  = $clog2(NUM_ARCH_REGS);
    localparam int PHYS_BITS  = $clog2(NUM_PHYS_REGS);
    localparam int COUNT_BITS = $clog2(NUM_PHYS_REGS + 1);

    //////////////////////////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////////////////////////

    typedef logic [ARCH_BITS-1:0]     arch_reg_t;
    typedef logic [PHYS_BITS-1:0]     phys_tag_t;
    typedef logic [COUNT_BITS-1:0]    free_count_t;
    typedef logic [NUM_PHYS_REGS-1:0] phys_mask_t;

    // One physical tag per architectural register
    typedef phys_tag_t [NUM_ARCH_REGS-1:0] map_array_t;

    // Map where arch register N sits in physical register N
    function automatic map_array_t identity_map();
        map_array_t map;
        for (int a = 0; a < NUM_ARCH_REGS; a++) begin
            map[a] = phys_tag_t'(a);
        end
        return map;
    endfunction

endpackage
